/* verilog/edge_settings.svh */
/*
 * frame geometry and sample widths for the Sobel edge detector
 * image size, pixel and counter widths, kernel size
 */

`ifndef EDGE_SETTINGS_SVH
`define EDGE_SETTINGS_SVH

// pixels per row, also the depth of every line delay
`define IMG_WIDTH 16

// rows per frame
`define IMG_HEIGHT 12

// greyscale sample width
`define PIX_WIDTH 12

// column and row counter width
`define COORD_WIDTH 11

// window rows, one row stage each
`define WIN_ROWS 3

`endif

/* verilog/videoPkg.sv */
/*
 * video stream types
 * greyscale sample and frame coordinate
 */

`default_nettype none

`include "edge_settings.svh"

package videoPkg;

    ////////////////////////////////////////
    // stream types
    ////////////////////////////////////////

    // one greyscale sample, unsigned
    typedef logic [`PIX_WIDTH-1:0] pixelT;

    // column or row index
    // counts from 0 at the top left of the frame
    typedef logic [`COORD_WIDTH-1:0] coordT;

endpackage

`default_nettype wire

/* verilog/kernelPkg.sv */
/*
 * arithmetic types of the Sobel kernel
 * signed gradient sum and signed coefficient
 */

`default_nettype none

package kernelPkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////

    // worst case is 4 * 4095, well inside 16 bits signed
    localparam int SUM_WIDTH = 16;

    // coefficients run from -2 to +2
    localparam int COEFF_WIDTH = 3;

    ////////////////////////////////////////
    // types
    ////////////////////////////////////////

    // running gradient sum over the nine taps
    typedef logic signed [SUM_WIDTH-1:0] sumT;

    // one Sobel weight
    typedef logic signed [COEFF_WIDTH-1:0] coeffT;

endpackage

`default_nettype wire

/* verilog/pixelIntake.sv */
/*
 * input register stage of the edge detector
 * pixel, strobe and window-complete flag
 */

`default_nettype none

`include "edge_settings.svh"

module pixelIntake (
    input  logic            iCLK,
    input  logic            iRST,
    input  videoPkg::pixelT iPixel,
    input  logic            iValid,
    input  videoPkg::coordT iX,
    input  videoPkg::coordT iY,
    output videoPkg::pixelT oPixel,
    output logic            oValid,
    output logic            oWindowFull
);

    import videoPkg::*;

    // kernel reaches this many columns left and rows up
    localparam coordT REACH = coordT'(`WIN_ROWS - 1);

    logic windowFull;

    // window needs two earlier columns and two earlier rows
    assign windowFull = (iX >= REACH) && (iY >= REACH);

    ////////////////////////////////////////
    // control
    ////////////////////////////////////////

    always_ff @(posedge iCLK or negedge iRST) begin
        if (!iRST) begin
            oValid      <= 1'b0;
            oWindowFull <= 1'b0;
        end else begin
            oValid      <= iValid;
            // flag travels with its pixel
            oWindowFull <= windowFull;
        end
    end

    // sample only on a strobe
    always_ff @(posedge iCLK) begin
        if (iValid) begin
            oPixel <= iPixel;
        end
    end

endmodule

`default_nettype wire

/* verilog/rowWindow.sv */
/*
 * one row of the 3x3 window
 * three-tap horizontal shift and a one-line circular delay
 */

`default_nettype none

`include "edge_settings.svh"

module rowWindow (
    input  logic            iCLK,
    input  logic            iRST,
    input  videoPkg::pixelT iPixel,
    input  logic            iValid,
    output videoPkg::pixelT oTapOld,
    output videoPkg::pixelT oTapMid,
    output videoPkg::pixelT oTapNew,
    output videoPkg::pixelT oNextRow
);

    import videoPkg::*;

    localparam int PTR_WIDTH = $clog2(`IMG_WIDTH);
    localparam logic [PTR_WIDTH-1:0] LAST = PTR_WIDTH'(`IMG_WIDTH - 1);

    // one row of samples
    pixelT lineMem [`IMG_WIDTH];

    // read and write share one slot
    logic [PTR_WIDTH-1:0] ptr;

    ////////////////////////////////////////
    // horizontal taps
    ////////////////////////////////////////

    // oldest is column x-2, newest column x
    always_ff @(posedge iCLK) begin
        if (iValid) begin
            oTapOld <= oTapMid;
            oTapMid <= oTapNew;
            oTapNew <= iPixel;
        end
    end

    ////////////////////////////////////////
    // line delay
    ////////////////////////////////////////

    // slot still holds the sample from one row back
    assign oNextRow = lineMem[ptr];

    always_ff @(posedge iCLK) begin
        if (iValid) begin
            lineMem[ptr] <= iPixel;
        end
    end

    // wraps after a full row of strobes
    always_ff @(posedge iCLK or negedge iRST) begin
        if (!iRST) begin
            ptr <= '0;
        end else if (iValid) begin
            ptr <= (ptr == LAST) ? '0 : ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* verilog/sobelKernel.sv */
/*
 * Sobel gradient over a 3x3 window
 * coefficient select, signed sum, magnitude, saturation
 * border mask and output register
 */

`default_nettype none

`include "edge_settings.svh"

module sobelKernel (
    input  logic            iCLK,
    input  logic            iRST,
    input  logic            iValid,
    input  logic            iWindowFull,
    input  logic            iVertical,
    input  videoPkg::pixelT iTop0,
    input  videoPkg::pixelT iTop1,
    input  videoPkg::pixelT iTop2,
    input  videoPkg::pixelT iMid0,
    input  videoPkg::pixelT iMid1,
    input  videoPkg::pixelT iMid2,
    input  videoPkg::pixelT iBot0,
    input  videoPkg::pixelT iBot1,
    input  videoPkg::pixelT iBot2,
    output videoPkg::pixelT oEdge,
    output logic            oValid
);

    import videoPkg::*;
    import kernelPkg::*;

    localparam int TAPS = 9;

    // largest sample value
    localparam sumT PIX_MAX = sumT'((1 << `PIX_WIDTH) - 1);

    pixelT tap   [TAPS];
    coeffT coeff [TAPS];
    sumT   sum;
    sumT   mag;
    pixelT satVal;
    pixelT edgeNext;

    // strobe and flag, aligned with the row taps
    logic validD;
    logic fullD;

    // raster order, top row first, oldest column first
    assign tap[0] = iTop0;
    assign tap[1] = iTop1;
    assign tap[2] = iTop2;
    assign tap[3] = iMid0;
    assign tap[4] = iMid1;
    assign tap[5] = iMid2;
    assign tap[6] = iBot0;
    assign tap[7] = iBot1;
    assign tap[8] = iBot2;

    ////////////////////////////////////////
    // coefficient select
    ////////////////////////////////////////

    always_comb begin
        if (iVertical) begin
            // vertical edge, weights left to right
            coeff[0] = -3'sd1;
            coeff[1] = 3'sd0;
            coeff[2] = 3'sd1;
            coeff[3] = -3'sd2;
            coeff[4] = 3'sd0;
            coeff[5] = 3'sd2;
            coeff[6] = -3'sd1;
            coeff[7] = 3'sd0;
            coeff[8] = 3'sd1;
        end else begin
            // horizontal edge, weights top to bottom
            coeff[0] = -3'sd1;
            coeff[1] = -3'sd2;
            coeff[2] = -3'sd1;
            coeff[3] = 3'sd0;
            coeff[4] = 3'sd0;
            coeff[5] = 3'sd0;
            coeff[6] = 3'sd1;
            coeff[7] = 3'sd2;
            coeff[8] = 3'sd1;
        end
    end

    ////////////////////////////////////////
    // sum, magnitude, saturate, mask
    ////////////////////////////////////////

    // samples widened with a zero sign bit
    always_comb begin
        sum = '0;
        for (int i = 0; i < TAPS; i++) begin
            sum = sum + sumT'(coeff[i]) * sumT'({1'b0, tap[i]});
        end
    end

    assign mag      = sum[$bits(sumT)-1] ? -sum : sum;
    assign satVal   = (mag > PIX_MAX) ? '1 : pixelT'(mag);
    // window reaching past the frame gives zero
    assign edgeNext = fullD ? satVal : '0;

    ////////////////////////////////////////
    // registers
    ////////////////////////////////////////

    always_ff @(posedge iCLK or negedge iRST) begin
        if (!iRST) begin
            validD <= 1'b0;
            fullD  <= 1'b0;
            oValid <= 1'b0;
            oEdge  <= '0;
        end else begin
            validD <= iValid;
            // flag held through a stall, like the taps
            if (iValid) begin
                fullD <= iWindowFull;
            end
            oValid <= validD;
            if (validD) begin
                oEdge <= edgeNext;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/edgeDetector.sv */
/*
 * top level of the Sobel edge detector
 * intake stage, chain of row stages, kernel
 */

`default_nettype none

`include "edge_settings.svh"

module edgeDetector (
    input  logic            iCLK,
    input  logic            iRST,
    input  videoPkg::pixelT iPixel,
    input  logic            iValid,
    input  videoPkg::coordT iX,
    input  videoPkg::coordT iY,
    input  logic            iVertical,
    output videoPkg::pixelT oEdge,
    output logic            oValid
);

    import videoPkg::*;

    // stage index of each window row
    localparam int TOP = `WIN_ROWS - 1;
    localparam int MID = TOP - 1;
    localparam int BOT = 0;

    // entry k feeds stage k, last entry is the unused line delay
    pixelT rowChain [`WIN_ROWS+1];

    pixelT tapOld [`WIN_ROWS];
    pixelT tapMid [`WIN_ROWS];
    pixelT tapNew [`WIN_ROWS];

    logic intakeValid;
    logic windowFull;

    ////////////////////////////////////////
    // intake
    ////////////////////////////////////////

    pixelIntake uIntake (
        .iCLK        (iCLK),
        .iRST        (iRST),
        .iPixel      (iPixel),
        .iValid      (iValid),
        .iX          (iX),
        .iY          (iY),
        .oPixel      (rowChain[0]),
        .oValid      (intakeValid),
        .oWindowFull (windowFull)
    );

    ////////////////////////////////////////
    // row stages
    ////////////////////////////////////////

    // stage 0 holds the current row, each next stage one row older
    for (genvar k = 0; k < `WIN_ROWS; k++) begin : gRow
        rowWindow uRow (
            .iCLK     (iCLK),
            .iRST     (iRST),
            .iPixel   (rowChain[k]),
            .iValid   (intakeValid),
            .oTapOld  (tapOld[k]),
            .oTapMid  (tapMid[k]),
            .oTapNew  (tapNew[k]),
            .oNextRow (rowChain[k+1])
        );
    end

    ////////////////////////////////////////
    // kernel
    ////////////////////////////////////////

    // oldest row on top
    sobelKernel uKernel (
        .iCLK        (iCLK),
        .iRST        (iRST),
        .iValid      (intakeValid),
        .iWindowFull (windowFull),
        .iVertical   (iVertical),
        .iTop0       (tapOld[TOP]),
        .iTop1       (tapMid[TOP]),
        .iTop2       (tapNew[TOP]),
        .iMid0       (tapOld[MID]),
        .iMid1       (tapMid[MID]),
        .iMid2       (tapNew[MID]),
        .iBot0       (tapOld[BOT]),
        .iBot1       (tapMid[BOT]),
        .iBot2       (tapNew[BOT]),
        .oEdge       (oEdge),
        .oValid      (oValid)
    );

endmodule

`default_nettype wire

/* verif/clockGen.sv */
/*
 * testbench clock and active low reset
 */

`default_nettype none

module clockGen #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 5
) (
    output logic oCLK,
    output logic oRST
);

    // free running, period 10
    initial begin
        oCLK = 1'b0;
        forever begin
            #HALF_PERIOD oCLK = ~oCLK;
        end
    end

    // held low for the first cycles, released on a falling edge
    initial begin
        oRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge oCLK);
        @(negedge oCLK);
        oRST = 1'b1;
    end

endmodule

`default_nettype wire

/* verif/edgeDetector_props.sv */
/*
 * concurrent checks bound to the edge detector top level
 * output strobe latency and border suppression
 */

`default_nettype none

`include "edge_settings.svh"

module edgeDetectorProps (
    input logic            iCLK,
    input logic            iRST,
    input logic            iValid,
    input videoPkg::coordT iX,
    input videoPkg::coordT iY,
    input videoPkg::pixelT oEdge,
    input logic            oValid
);

    import videoPkg::*;

    // columns and rows the kernel reaches back
    localparam coordT REACH = coordT'(`WIN_ROWS - 1);

    ////////////////////////////////////////
    // properties
    ////////////////////////////////////////

    // three registers through intake, row stage and kernel
    property pValidLatency;
        @(posedge iCLK) disable iff (!iRST)
            oValid == $past(iValid, 3);
    endproperty

    // window reaching past the left or top edge
    property pBorderZero;
        @(posedge iCLK) disable iff (!iRST)
            (oValid && (($past(iX, 3) < REACH) || ($past(iY, 3) < REACH)))
                |-> (oEdge == '0);
    endproperty

    aValidLatency: assert property (pValidLatency)
        else $error("oValid does not follow iValid by three cycles");

    aBorderZero: assert property (pBorderZero)
        else $error("nonzero edge value for a border pixel");

endmodule

`default_nettype wire

/* verif/tbEdgeDetector.sv */
/*
 * testbench of the Sobel edge detector
 * LCG stimulus, reference model, compare process
 */

`default_nettype none

`include "edge_settings.svh"

module tbEdgeDetector;

    import videoPkg::*;

    localparam int W          = `IMG_WIDTH;
    localparam int H          = `IMG_HEIGHT;
    localparam int PIX_MAX    = (1 << `PIX_WIDTH) - 1;
    localparam int WAIT_LIMIT = 100;

    logic  iCLK;
    logic  iRST;
    pixelT iPixel;
    logic  iValid;
    coordT iX;
    coordT iY;
    logic  iVertical;
    pixelT oEdge;
    logic  oValid;

    // frame being sent as [row][column]
    pixelT       frame [H][W];
    // one expected edge value per accepted pixel
    pixelT       expQ [$];
    logic [31:0] lcgState  = 32'h09b0921f;
    int          sentCount = 0;
    int          outCount  = 0;

    clockGen uClock (
        .oCLK (iCLK),
        .oRST (iRST)
    );

    edgeDetector u_dut (
        .iCLK      (iCLK),
        .iRST      (iRST),
        .iPixel    (iPixel),
        .iValid    (iValid),
        .iX        (iX),
        .iY        (iY),
        .iVertical (iVertical),
        .oEdge     (oEdge),
        .oValid    (oValid)
    );

    bind edgeDetector edgeDetectorProps uProps (
        .iCLK   (iCLK),
        .iRST   (iRST),
        .iValid (iValid),
        .iX     (iX),
        .iY     (iY),
        .oEdge  (oEdge),
        .oValid (oValid)
    );

    ////////////////////////////////////////
    // helpers and reference model
    ////////////////////////////////////////

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // signed sum over rows y-2..y and columns x-2..x
    function automatic int gradientSum(input int x, input int y, input logic vertical);
        int sum;
        int w;
        sum = 0;
        for (int k = 0; k < 3; k++) begin
            // centre row or column weighs double
            w = (k == 1) ? 2 : 1;
            if (vertical) begin
                sum += w * (int'(frame[y-2+k][x]) - int'(frame[y-2+k][x-2]));
            end else begin
                sum += w * (int'(frame[y][x-2+k]) - int'(frame[y-2][x-2+k]));
            end
        end
        return sum;
    endfunction

    // saturated magnitude and zero at the border
    function automatic int expectedEdge(input int x, input int y, input logic vertical);
        int mag;
        if (x < 2 || y < 2) begin
            return 0;
        end
        mag = gradientSum(x, y, vertical);
        mag = (mag < 0) ? -mag : mag;
        return (mag > PIX_MAX) ? PIX_MAX : mag;
    endfunction

    task automatic abortRun();
        $display("Test failures found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkEqual(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("Mismatch at time %0t: %s is %0d, expected %0d",
                     $time, what, actual, expected);
            abortRun();
        end
    endtask

    task automatic waitForReset();
        int waited;
        waited = 0;
        while (iRST !== 1'b1) begin
            @(negedge iCLK);
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("Timeout: reset was never released");
                abortRun();
            end
        end
    endtask

    ////////////////////////////////////////
    // stimulus tasks
    ////////////////////////////////////////

    task automatic fillRandom();
        for (int y = 0; y < H; y++) begin
            for (int x = 0; x < W; x++) begin
                frame[y][x] = pixelT'(nextRandom() >> 20);
            end
        end
    endtask

    // dark left half and full scale right half
    task automatic fillStep();
        for (int y = 0; y < H; y++) begin
            for (int x = 0; x < W; x++) begin
                frame[y][x] = (x < W / 2) ? pixelT'(0) : pixelT'(PIX_MAX);
            end
        end
    endtask

    task automatic drivePixel(input int x, input int y);
        @(negedge iCLK);
        iPixel = frame[y][x];
        iX     = coordT'(x);
        iY     = coordT'(y);
        iValid = 1'b1;
        expQ.push_back(pixelT'(expectedEdge(x, y, iVertical)));
        sentCount++;
    endtask

    // raster order with optional random gaps before each pixel
    task automatic sendFrame(input logic vertical, input logic withStalls);
        int gap;
        iVertical = vertical;
        for (int y = 0; y < H; y++) begin
            for (int x = 0; x < W; x++) begin
                gap = withStalls ? int'(nextRandom() >> 30) : 0;
                for (int g = 0; g < gap; g++) begin
                    @(negedge iCLK);
                    iValid = 1'b0;
                    // junk during a stall must not enter the window
                    iPixel = pixelT'(nextRandom() >> 20);
                end
                drivePixel(x, y);
            end
        end
    endtask

    task automatic drainOutputs();
        int waited;
        waited = 0;
        @(negedge iCLK);
        iValid = 1'b0;
        while (expQ.size() != 0) begin
            @(negedge iCLK);
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("Timeout: %0d outputs still missing", expQ.size());
                abortRun();
            end
        end
        // any extra strobe shows up here
        repeat (4) @(negedge iCLK);
    endtask

    ////////////////////////////////////////
    // compare process
    ////////////////////////////////////////

    // outputs change on the rising edge and are sampled on the falling one
    initial begin : compareOutputs
        int    idle;
        pixelT expEdge;
        waitForReset();
        forever begin
            idle = 0;
            @(negedge iCLK);
            while (!oValid) begin
                if (expQ.size() != 0) begin
                    idle++;
                end
                if (idle > WAIT_LIMIT) begin
                    $display("Timeout: no output for a pending pixel");
                    abortRun();
                end
                @(negedge iCLK);
            end
            if (expQ.size() == 0) begin
                $display("Output strobe without an accepted pixel at time %0t", $time);
                abortRun();
            end
            expEdge = expQ.pop_front();
            checkEqual(oEdge, expEdge, $sformatf("oEdge of output %0d", outCount));
            outCount++;
        end
    end

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin : stimulus
        iPixel    = '0;
        iValid    = 1'b0;
        iX        = '0;
        iY        = '0;
        iVertical = 1'b1;
        waitForReset();

        // quiet outputs before the first pixel
        repeat (8) begin
            @(negedge iCLK);
            checkEqual(oValid, 0, "oValid before the first pixel");
            checkEqual(oEdge, 0, "oEdge before the first pixel");
        end

        // one random frame through vertical, horizontal and stalled runs
        fillRandom();
        sendFrame(1'b1, 1'b0);
        drainOutputs();
        sendFrame(1'b0, 1'b0);
        drainOutputs();
        sendFrame(1'b1, 1'b1);
        drainOutputs();

        // step frame with a random frame right behind it
        fillStep();
        sendFrame(1'b1, 1'b0);
        fillRandom();
        sendFrame(1'b1, 1'b0);
        drainOutputs();

        if (outCount == sentCount) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Mismatch at time %0t: %0d outputs for %0d accepted pixels",
                     $time, outCount, sentCount);
            abortRun();
        end
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+verilog
verilog/videoPkg.sv
verilog/kernelPkg.sv
verilog/pixelIntake.sv
verilog/rowWindow.sv
verilog/sobelKernel.sv
verilog/edgeDetector.sv
verif/clockGen.sv
verif/edgeDetector_props.sv
verif/tbEdgeDetector.sv

/* run.sh */
#!/bin/sh
# build and run the edge detector testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module tbEdgeDetector -o simEdge

# a failing run still prints, the search decides the status
out=$(./obj_dir/simEdge || true)
echo "$out"
echo "$out" | grep -qF "All tests passed!"
